// ==== common/fp_isa_pkg.sv ====
package fp_isa_pkg;

  // widths with a meaning in the RISC-V F extension
  typedef logic [31:0] fp_word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0] fflags_t;   // NV DZ OF UF NX from high to low
  typedef logic [2:0] frm_t;

  typedef enum logic [3:0] {
    op_sgnj,
    op_sgnjn,
    op_sgnjx,
    op_min,
    op_max,
    op_eq,
    op_lt,
    op_le,
    op_mv_f2i,
    op_mv_i2f,
    op_class,
    op_csrrw,
    op_csrrs
  } fp_op_e;

  localparam logic [6:0] opcode_fp = 7'h53;
  localparam logic [6:0] opcode_system = 7'h73;

  // upper five bits of funct7, the low two bits hold the format
  localparam logic [4:0] funct5_sgnj = 5'b00100;
  localparam logic [4:0] funct5_minmax = 5'b00101;
  localparam logic [4:0] funct5_cmp = 5'b10100;
  localparam logic [4:0] funct5_mv_f2i = 5'b11100;   // shared with fclass
  localparam logic [4:0] funct5_mv_i2f = 5'b11110;
  localparam logic [1:0] fmt_s = 2'b00;

  localparam logic [2:0] funct3_csrrw = 3'd1;
  localparam logic [2:0] funct3_csrrs = 3'd2;

  localparam csr_addr_t csr_fflags = 12'h001;
  localparam csr_addr_t csr_frm = 12'h002;
  localparam csr_addr_t csr_fcsr = 12'h003;

  localparam fp_word_t canonical_nan = 32'h7fc00000;

  // bit positions of the fclass result
  localparam int fclass_neg_inf = 0;
  localparam int fclass_neg_norm = 1;
  localparam int fclass_neg_sub = 2;
  localparam int fclass_neg_zero = 3;
  localparam int fclass_pos_zero = 4;
  localparam int fclass_pos_sub = 5;
  localparam int fclass_pos_norm = 6;
  localparam int fclass_pos_inf = 7;
  localparam int fclass_snan = 8;
  localparam int fclass_qnan = 9;

endpackage

// ==== common/fpu_bus_pkg.sv ====
package fpu_bus_pkg;

  // one instruction as the host hands it over
  typedef struct packed {
    fp_isa_pkg::instr_t instr;
    fp_isa_pkg::fp_word_t int_operand;
  } fpu_req_t;

  typedef struct packed {
    fp_isa_pkg::fp_op_e op;
    fp_isa_pkg::reg_addr_t rd;
    fp_isa_pkg::reg_addr_t rs1;
    fp_isa_pkg::reg_addr_t rs2;
    fp_isa_pkg::csr_addr_t csr_addr;
    logic writes_fp;
    logic writes_int;
    logic illegal;
  } fp_ctrl_t;

  // flags is the fflags value once the instruction has retired
  typedef struct packed {
    fp_isa_pkg::fp_word_t result;
    fp_isa_pkg::reg_addr_t rd;
    logic writes_fp;
    logic illegal;
    fp_isa_pkg::fflags_t flags;
  } fpu_rsp_t;

endpackage

// ==== rtl/fpu_intake.sv ====
`timescale 1ns/1ns

module fpu_intake (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_i,
  input  fpu_bus_pkg::fpu_req_t request_i,
  input  logic                  free_i,
  output logic                  ack_o,
  output logic                  issue_o,
  output fpu_bus_pkg::fpu_req_t held_o
);
  import fpu_bus_pkg::*;

  typedef enum logic [1:0] {st_idle, st_acked, st_wait_low} state_e;

  state_e state;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req_i && free_i) state <= st_acked;
        st_acked: state <= req_i ? st_wait_low : st_idle;
        st_wait_low: if (!req_i) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && req_i && free_i) held_o <= request_i;
  end

  assign issue_o = (state == st_acked);   // first cycle after accept only
  assign ack_o = (state != st_idle);

  // the host must still be requesting at the edge where ack is raised
  ack_needs_req: assert property (@(posedge clock) disable iff (!reset)
    $rose(ack_o) |-> req_i);

endmodule

// ==== fpu_core/fpu_decode.sv ====
`timescale 1ns/1ns

module fpu_decode (
  input  fp_isa_pkg::instr_t     instr_i,
  output fpu_bus_pkg::fp_ctrl_t  ctrl_o
);
  import fp_isa_pkg::*;
  import fpu_bus_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    ctrl_o = '0;
    ctrl_o.op = op_sgnj;
    ctrl_o.rd = instr_i[11:7];
    ctrl_o.rs1 = instr_i[19:15];
    ctrl_o.rs2 = instr_i[24:20];
    ctrl_o.csr_addr = instr_i[31:20];
    case (opcode)
      opcode_fp: begin
        if (funct7[1:0] != fmt_s) ctrl_o.illegal = 1'b1;   // only single precision
        case (funct7[6:2])
          funct5_sgnj: begin
            ctrl_o.writes_fp = 1'b1;
            case (funct3)
              3'd0: ctrl_o.op = op_sgnj;
              3'd1: ctrl_o.op = op_sgnjn;
              3'd2: ctrl_o.op = op_sgnjx;
              default: ctrl_o.illegal = 1'b1;
            endcase
          end
          funct5_minmax: begin
            ctrl_o.writes_fp = 1'b1;
            ctrl_o.op = (funct3 == 3'd1) ? op_max : op_min;
            if (funct3 > 3'd1) ctrl_o.illegal = 1'b1;
          end
          funct5_cmp: begin
            ctrl_o.writes_int = 1'b1;
            case (funct3)
              3'd0: ctrl_o.op = op_le;
              3'd1: ctrl_o.op = op_lt;
              3'd2: ctrl_o.op = op_eq;
              default: ctrl_o.illegal = 1'b1;
            endcase
          end
          funct5_mv_f2i: begin
            ctrl_o.writes_int = 1'b1;
            ctrl_o.op = (funct3 == 3'd1) ? op_class : op_mv_f2i;
            if (funct3 > 3'd1) ctrl_o.illegal = 1'b1;
          end
          funct5_mv_i2f: begin
            ctrl_o.writes_fp = 1'b1;
            ctrl_o.op = op_mv_i2f;
            if (funct3 != 3'd0) ctrl_o.illegal = 1'b1;
          end
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      opcode_system: begin
        ctrl_o.writes_int = 1'b1;
        ctrl_o.op = (funct3 == funct3_csrrs) ? op_csrrs : op_csrrw;
        if (funct3 != funct3_csrrw && funct3 != funct3_csrrs) ctrl_o.illegal = 1'b1;
        if (ctrl_o.csr_addr != csr_fflags && ctrl_o.csr_addr != csr_frm &&
            ctrl_o.csr_addr != csr_fcsr) ctrl_o.illegal = 1'b1;
      end
      default: ctrl_o.illegal = 1'b1;
    endcase
    if (ctrl_o.illegal) begin
      // an illegal instruction leaves every register alone
      ctrl_o.writes_fp = 1'b0;
      ctrl_o.writes_int = 1'b0;
    end
  end

endmodule

// ==== fpu_core/fpu_regfile.sv ====
`timescale 1ns/1ns

module fpu_regfile (
  input  logic                     clock,
  input  logic                     reset,
  input  fp_isa_pkg::reg_addr_t    raddr1_i,
  input  fp_isa_pkg::reg_addr_t    raddr2_i,
  output fp_isa_pkg::fp_word_t     rdata1_o,
  output fp_isa_pkg::fp_word_t     rdata2_o,
  input  logic                     wen_i,
  input  fp_isa_pkg::reg_addr_t    waddr_i,
  input  fp_isa_pkg::fp_word_t     wdata_i
);
  import fp_isa_pkg::*;

  fp_word_t regs [32];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;   // f0 is a normal register
    end else if (wen_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// ==== fpu_core/fpu_alu.sv ====
`timescale 1ns/1ns

module fpu_alu (
  input  fp_isa_pkg::fp_op_e   op_i,
  input  fp_isa_pkg::fp_word_t a_i,
  input  fp_isa_pkg::fp_word_t b_i,
  input  fp_isa_pkg::fp_word_t int_i,
  output fp_isa_pkg::fp_word_t result_o,
  output logic                 invalid_o
);
  import fp_isa_pkg::*;

  logic a_sign, b_sign, a_exp_max, b_exp_max, a_exp_zero, a_man_zero, b_man_zero;
  logic a_nan, b_nan, any_nan, any_snan, both_zero;
  logic ord_lt, ord_eq, tot_lt;
  logic [9:0] class_bits;

  assign a_sign = a_i[31];
  assign b_sign = b_i[31];
  assign a_exp_max = (a_i[30:23] == 8'hff);
  assign b_exp_max = (b_i[30:23] == 8'hff);
  assign a_exp_zero = (a_i[30:23] == 8'h00);
  assign a_man_zero = (a_i[22:0] == '0);
  assign b_man_zero = (b_i[22:0] == '0);
  assign a_nan = a_exp_max & ~a_man_zero;
  assign b_nan = b_exp_max & ~b_man_zero;
  assign any_nan = a_nan | b_nan;
  assign any_snan = (a_nan & ~a_i[22]) | (b_nan & ~b_i[22]);   // quiet bit clear
  assign both_zero = (a_i[30:0] == '0) && (b_i[30:0] == '0);

  // ordered compare, -0 and +0 are equal here
  always_comb begin
    if (a_sign != b_sign) ord_lt = a_sign & ~both_zero;
    else if (!a_sign) ord_lt = a_i[30:0] < b_i[30:0];
    else ord_lt = b_i[30:0] < a_i[30:0];
  end
  assign ord_eq = (a_i == b_i) | both_zero;
  assign tot_lt = ord_lt | (both_zero & a_sign & ~b_sign);   // min/max put -0 below +0

  always_comb begin
    class_bits = '0;
    class_bits[fclass_neg_inf] = a_sign & a_exp_max & a_man_zero;
    class_bits[fclass_neg_norm] = a_sign & ~a_exp_max & ~a_exp_zero;
    class_bits[fclass_neg_sub] = a_sign & a_exp_zero & ~a_man_zero;
    class_bits[fclass_neg_zero] = a_sign & a_exp_zero & a_man_zero;
    class_bits[fclass_pos_zero] = ~a_sign & a_exp_zero & a_man_zero;
    class_bits[fclass_pos_sub] = ~a_sign & a_exp_zero & ~a_man_zero;
    class_bits[fclass_pos_norm] = ~a_sign & ~a_exp_max & ~a_exp_zero;
    class_bits[fclass_pos_inf] = ~a_sign & a_exp_max & a_man_zero;
    class_bits[fclass_snan] = a_nan & ~a_i[22];
    class_bits[fclass_qnan] = a_nan & a_i[22];
  end

  always_comb begin
    result_o = a_i;
    invalid_o = 1'b0;
    case (op_i)
      op_sgnj: result_o = {b_sign, a_i[30:0]};
      op_sgnjn: result_o = {~b_sign, a_i[30:0]};
      op_sgnjx: result_o = {a_sign ^ b_sign, a_i[30:0]};
      op_min, op_max: begin
        invalid_o = any_snan;
        if (a_nan && b_nan) result_o = canonical_nan;
        else if (a_nan) result_o = b_i;
        else if (b_nan) result_o = a_i;
        else if (op_i == op_min) result_o = tot_lt ? a_i : b_i;
        else result_o = tot_lt ? b_i : a_i;
      end
      op_eq: begin
        invalid_o = any_snan;   // feq is a quiet compare
        result_o = {31'b0, ~any_nan & ord_eq};
      end
      op_lt: begin
        invalid_o = any_nan;
        result_o = {31'b0, ~any_nan & ord_lt};
      end
      op_le: begin
        invalid_o = any_nan;
        result_o = {31'b0, ~any_nan & (ord_lt | ord_eq)};
      end
      op_mv_i2f: result_o = int_i;
      op_class: result_o = {22'b0, class_bits};
      default: result_o = a_i;   // fmv.x.w, and CSR ops take the CSR value in the top
    endcase
  end

endmodule

// ==== fpu_core/fpu_csr.sv ====
`timescale 1ns/1ns

module fpu_csr (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_i,
  input  fpu_bus_pkg::fp_ctrl_t ctrl_i,
  input  fp_isa_pkg::fp_word_t  wdata_i,
  input  fp_isa_pkg::fflags_t   flags_i,
  output fp_isa_pkg::fp_word_t  rdata_o,
  output fp_isa_pkg::fflags_t   fflags_o
);
  import fp_isa_pkg::*;

  fflags_t fflags, fflags_next;
  frm_t frm, frm_next;
  fp_word_t wval;
  logic is_csr;

  assign is_csr = (ctrl_i.op == op_csrrw) || (ctrl_i.op == op_csrrs);

  always_comb begin
    case (ctrl_i.csr_addr)
      csr_fflags: rdata_o = {27'b0, fflags};
      csr_frm: rdata_o = {29'b0, frm};
      csr_fcsr: rdata_o = {24'b0, frm, fflags};
      default: rdata_o = '0;
    endcase
  end

  assign wval = (ctrl_i.op == op_csrrw) ? wdata_i : (rdata_o | wdata_i);

  always_comb begin
    fflags_next = fflags;
    frm_next = frm;
    if (issue_i && !ctrl_i.illegal) begin
      if (is_csr) begin
        if (ctrl_i.csr_addr != csr_frm) fflags_next = wval[4:0];
        if (ctrl_i.csr_addr == csr_frm) frm_next = wval[2:0];
        if (ctrl_i.csr_addr == csr_fcsr) frm_next = wval[7:5];
      end else begin
        fflags_next = fflags | flags_i;   // flags only ever accrue
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fflags <= '0;
      frm <= '0;
    end else begin
      fflags <= fflags_next;
      frm <= frm_next;
    end
  end

  assign fflags_o = fflags_next;

endmodule

// ==== rtl/fpu_respond.sv ====
`timescale 1ns/1ns

module fpu_respond (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_i,
  input  fpu_bus_pkg::fpu_rsp_t result_i,
  input  logic                  rsp_ack_i,
  output logic                  free_o,
  output logic                  rsp_req_o,
  output fpu_bus_pkg::fpu_rsp_t response_o
);
  import fpu_bus_pkg::*;

  typedef enum logic [1:0] {st_free, st_pending, st_release} state_e;

  state_e state;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_free;
    end else begin
      case (state)
        st_free: if (issue_i) state <= st_pending;
        st_pending: if (rsp_ack_i) state <= st_release;
        st_release: if (!rsp_ack_i) state <= st_free;   // consumer has let go
        default: state <= st_free;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_free && issue_i) response_o <= result_i;
  end

  assign rsp_req_o = (state == st_pending);
  assign free_o = (state == st_free);

  // a result issued while a response is still pending would be lost
  issue_when_free: assert property (@(posedge clock) disable iff (!reset)
    issue_i |-> free_o);

endmodule

// ==== rtl/fpu_top.sv ====
`timescale 1ns/1ns

module fpu_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_i,
  input  fpu_bus_pkg::fpu_req_t request_i,
  output logic                  ack_o,
  output logic                  rsp_req_o,
  input  logic                  rsp_ack_i,
  output fpu_bus_pkg::fpu_rsp_t response_o
);
  import fp_isa_pkg::*;
  import fpu_bus_pkg::*;

  logic issue, free, alu_invalid, fp_wen;
  fpu_req_t held;
  fp_ctrl_t ctrl;
  fp_word_t rdata1, rdata2, alu_result, csr_rdata, result_word;
  fflags_t fflags_now;
  fpu_rsp_t rsp;

  fpu_intake i_fpu_intake (
    .clock(clock), .reset(reset), .req_i(req_i), .request_i(request_i),
    .free_i(free), .ack_o(ack_o), .issue_o(issue), .held_o(held)
  );

  fpu_decode i_fpu_decode (.instr_i(held.instr), .ctrl_o(ctrl));

  fpu_regfile i_fpu_regfile (
    .clock(clock), .reset(reset), .raddr1_i(ctrl.rs1), .raddr2_i(ctrl.rs2),
    .rdata1_o(rdata1), .rdata2_o(rdata2), .wen_i(fp_wen), .waddr_i(ctrl.rd),
    .wdata_i(result_word)
  );

  fpu_alu i_fpu_alu (
    .op_i(ctrl.op), .a_i(rdata1), .b_i(rdata2), .int_i(held.int_operand),
    .result_o(alu_result), .invalid_o(alu_invalid)
  );

  fpu_csr i_fpu_csr (
    .clock(clock), .reset(reset), .issue_i(issue), .ctrl_i(ctrl),
    .wdata_i(held.int_operand), .flags_i({alu_invalid, 4'b0}),
    .rdata_o(csr_rdata), .fflags_o(fflags_now)
  );

  assign result_word = (ctrl.op == op_csrrw || ctrl.op == op_csrrs) ? csr_rdata : alu_result;
  assign fp_wen = issue & ctrl.writes_fp & ~ctrl.illegal;
  assign rsp = '{result: result_word, rd: ctrl.rd, writes_fp: ctrl.writes_fp,
                 illegal: ctrl.illegal, flags: fflags_now};

  fpu_respond i_fpu_respond (
    .clock(clock), .reset(reset), .issue_i(issue), .result_i(rsp),
    .rsp_ack_i(rsp_ack_i), .free_o(free), .rsp_req_o(rsp_req_o), .response_o(response_o)
  );

endmodule

// ==== bench/fpu_top_tb.sv ====
`timescale 1ns/1ns

module fpu_top_tb;
  import fp_isa_pkg::*;
  import fpu_bus_pkg::*;

  localparam int cycle_ns = 100;
  localparam int max_vectors = 64;
  localparam int cycles_per_test = 40;

  typedef logic [8*24-1:0] test_name_t;

  logic clock;
  logic reset;
  logic req_i;
  fpu_req_t request_i;
  logic ack_o;
  logic rsp_req_o;
  logic rsp_ack_i;
  fpu_rsp_t response_o;

  test_name_t name_mem [max_vectors];
  instr_t instr_mem [max_vectors];
  fp_word_t operand_mem [max_vectors];
  fp_word_t result_mem [max_vectors];
  logic wfp_mem [max_vectors];
  logic ill_mem [max_vectors];
  fflags_t flags_mem [max_vectors];

  int vec_count;
  int passed;
  int errors;
  int responses;
  integer seed;

  fpu_top i_fpu_top (
    .clock(clock), .reset(reset), .req_i(req_i), .request_i(request_i), .ack_o(ack_o),
    .rsp_req_o(rsp_req_o), .rsp_ack_i(rsp_ack_i), .response_o(response_o)
  );

  always #(cycle_ns / 2) clock = ~clock;

  task automatic load_vectors();
    int fd;
    int code;
    string line;
    test_name_t name;
    instr_t instr;
    fp_word_t operand;
    fp_word_t result;
    logic wfp;
    logic ill;
    fflags_t flags;
    vec_count = 0;
    fd = $fopen("bench/fpu_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vector file bench/fpu_vectors.txt could not be opened");
    end else begin
      while (!$feof(fd) && vec_count < max_vectors) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin   // skip comments
          code = $sscanf(line, "%s %h %h %h %b %b %h", name, instr, operand, result, wfp,
                         ill, flags);
          if (code == 7) begin
            name_mem[vec_count] = name;
            instr_mem[vec_count] = instr;
            operand_mem[vec_count] = operand;
            result_mem[vec_count] = result;
            wfp_mem[vec_count] = wfp;
            ill_mem[vec_count] = ill;
            flags_mem[vec_count] = flags;
            vec_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_word(input test_name_t name, input string field, input fp_word_t exp,
                            input fp_word_t act, inout logic ok);
    if (exp !== act) begin
      $display("FAILED %0s %0s expected %08h actual %08h", name, field, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic check_flags(input test_name_t name, input fflags_t exp, input fflags_t act,
                             inout logic ok);
    if (exp !== act) begin
      $display("FAILED %0s flags expected %05b actual %05b", name, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic check_bit(input test_name_t name, input string field, input logic exp,
                           input logic act, inout logic ok);
    if (exp !== act) begin
      $display("FAILED %0s %0s expected %0b actual %0b", name, field, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic check_addr(input test_name_t name, input reg_addr_t exp,
                            input reg_addr_t act, inout logic ok);
    if (exp !== act) begin
      $display("FAILED %0s rd expected %0d actual %0d", name, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic check_response(input int idx, input fpu_rsp_t rsp);
    logic ok;
    ok = 1'b1;
    // the result word of an illegal instruction carries no meaning
    if (!ill_mem[idx]) check_word(name_mem[idx], "result", result_mem[idx], rsp.result, ok);
    check_addr(name_mem[idx], instr_mem[idx][11:7], rsp.rd, ok);   // rd field of the encoding
    check_bit(name_mem[idx], "writes_fp", wfp_mem[idx], rsp.writes_fp, ok);
    check_bit(name_mem[idx], "illegal", ill_mem[idx], rsp.illegal, ok);
    check_flags(name_mem[idx], flags_mem[idx], rsp.flags, ok);
    if (ok) begin
      passed++;
      $display("ok %0s", name_mem[idx]);
    end else begin
      errors++;
    end
  endtask

  task automatic send_request(input int idx);
    fpu_req_t req;
    req.instr = instr_mem[idx];
    req.int_operand = operand_mem[idx];
    @(posedge clock);
    req_i <= 1'b1;
    request_i <= req;
    do @(posedge clock); while (!ack_o);
    req_i <= 1'b0;
    do @(posedge clock); while (ack_o);   // four-phase, wait for ack to drop
  endtask

  task automatic collect_responses();
    fpu_rsp_t rsp;
    int extra;
    for (int i = 0; i < vec_count; i++) begin
      do @(posedge clock); while (!rsp_req_o);
      rsp = response_o;
      extra = $random(seed) & 7;   // slow consumer holds the unit busy
      repeat (extra) @(posedge clock);
      rsp_ack_i <= 1'b1;
      do @(posedge clock); while (rsp_req_o);
      rsp_ack_i <= 1'b0;
      responses++;
      check_response(i, rsp);
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    req_i = 1'b0;
    request_i = '0;
    rsp_ack_i = 1'b0;
    seed = 97;
    passed = 0;
    errors = 0;
    responses = 0;
    load_vectors();
    repeat (8) @(posedge clock);
    reset <= 1'b1;
    if (vec_count == 0) begin
      $display("no test vectors were read, nothing was run");
      errors++;
    end else begin
      fork
        for (int i = 0; i < vec_count; i++) send_request(i);
        collect_responses();
      join
      repeat (4) @(posedge clock);
      if (rsp_req_o) begin
        $display("the unit raised a response with no request left to answer");
        errors++;
      end
    end
    $display("%0d tests, %0d passed, %0d failed", vec_count, passed, vec_count - passed);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // vector count is known after time zero
  initial begin
    #1;
    #((vec_count * cycles_per_test + 12) * cycle_ns);
    $display("the handshake hung after %0d of %0d responses", responses, vec_count);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== bench/fpu_vectors.txt ====
# name  instruction  int_operand  expected_result  writes_fp  illegal  fflags (hex)
# instructions run in file order and later lines depend on earlier register and CSR state
rd_f5_reset e00280d3 00000000 00000000 0 0 00
mv_f1 f00000d3 3f800000 3f800000 1 0 00
mv_f2 f0000153 c0000000 c0000000 1 0 00
rd_f1 e00080d3 00000000 3f800000 0 0 00
sgnj_f3 202081d3 00000000 bf800000 1 0 00
sgnjn_f4 20209253 00000000 3f800000 1 0 00
sgnjx_f5 202122d3 00000000 40000000 1 0 00
rd_f3 e00180d3 00000000 bf800000 0 0 00
rd_f5 e00280d3 00000000 40000000 0 0 00
mv_f6_qnan f0000353 7fc00000 7fc00000 1 0 00
mv_f7_snan f00003d3 7f800001 7f800001 1 0 00
mv_f8_negzero f0000453 80000000 80000000 1 0 00
fmin_ordered 282084d3 00000000 c0000000 1 0 00
fmax_zeros 280414d3 00000000 00000000 1 0 00
fmax_one_nan 281314d3 00000000 3f800000 1 0 00
fmin_two_nan 287304d3 00000000 7fc00000 1 0 10
csrrw_fflags 001010f3 00000000 00000010 0 0 00
feq_qnan a01320d3 00000000 00000000 0 0 00
flt_qnan a01310d3 00000000 00000000 0 0 10
feq_zeros a00420d3 00000000 00000001 0 0 10
fle_ordered a01100d3 00000000 00000001 0 0 10
fclass_negnorm e00110d3 00000000 00000002 0 0 10
fclass_snan e00390d3 00000000 00000100 0 0 10
fclass_qnan e00310d3 00000000 00000200 0 0 10
csrrw_frm 002010f3 00000005 00000000 0 0 10
csrrs_fflags 001020f3 00000001 00000010 0 0 11
csrrs_fcsr 003020f3 00000000 000000b1 0 0 11
illegal_fadd 003100d3 00000000 00000000 0 1 11
rd_f1_after e00080d3 00000000 3f800000 0 0 11
illegal_csr 004010f3 000000ff 00000000 0 1 11
csrrs_frm 002020f3 00000000 00000005 0 0 11

// ==== vlog.f ====
common/fp_isa_pkg.sv
common/fpu_bus_pkg.sv
rtl/fpu_intake.sv
fpu_core/fpu_decode.sv
fpu_core/fpu_regfile.sv
fpu_core/fpu_alu.sv
fpu_core/fpu_csr.sv
rtl/fpu_respond.sv
rtl/fpu_top.sv
bench/fpu_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
  --top-module fpu_top_tb --Mdir obj_dir -o fpu_sim

./obj_dir/fpu_sim > sim.log 2>&1
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
